//--- hw/blimp_pkg.sv
//------------------------------------------------------------
// Blimp core package
// Opcode fields, operation and pipe encodings, and the
// structs passed between the pipeline stages
//------------------------------------------------------------

package blimp_pkg;

  //------------------------------------------------------------
  // Sizing
  //------------------------------------------------------------

  localparam int c_seq_bits  = 5;  // Matches the core's default
  localparam int c_num_pipes = 2;  // ALU and multiplier

  //------------------------------------------------------------
  // RV32 encodings in the subset
  //------------------------------------------------------------

  localparam logic [6:0] c_opc_op     = 7'b0110011;  // Reg-reg ops
  localparam logic [6:0] c_opc_op_imm = 7'b0010011;  // Reg-imm ops
  localparam logic [2:0] c_f3_add     = 3'b000;      // ADD, ADDI, MUL
  localparam logic [6:0] c_f7_add     = 7'b0000000;
  localparam logic [6:0] c_f7_mul     = 7'b0000001;  // M extension

  typedef enum logic [1:0] {
    op_add,
    op_addi,
    op_mul,
    op_nop    // Anything outside the subset
  } op_t;

  typedef enum logic {
    pipe_alu,
    pipe_mul
  } pipe_id_t;

  //------------------------------------------------------------
  // Stage-to-stage structs
  //------------------------------------------------------------

  typedef struct packed {
    logic                  val;
    logic [31:0]           pc;
    logic [31:0]           inst;
  } f_d_t;

  typedef struct packed {
    logic                  val;
    logic [c_seq_bits-1:0] seq;
    logic [31:0]           pc;    // Carried for the ROB
    logic [4:0]            waddr;
    logic                  wen;
    op_t                   op;
    logic [31:0]           op_a;
    logic [31:0]           op_b;  // Immediate already placed here for ADDI
  } d_x_t;

  typedef struct packed {
    logic                  val;
    logic [c_seq_bits-1:0] seq;
    logic [31:0]           pc;
    logic [4:0]            waddr;
    logic                  wen;
    logic [31:0]           wdata;
  } x_w_t;

  typedef struct packed {
    logic                  val;
    logic [c_seq_bits-1:0] seq;
    logic [31:0]           pc;
    logic [4:0]            waddr;
    logic                  wen;
    logic [31:0]           wdata;
  } commit_t;

endpackage

//--- hw/fetch_unit.sv
//------------------------------------------------------------
// Fetch unit
// Sequential PC, instruction memory requests and a one-entry
// hold buffer that parks a response while decode stalls
//------------------------------------------------------------

`timescale 1ns/1ns

module fetch_unit (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            decode_stall,
  output logic            imem_req,
  output logic [31:0]     imem_addr,
  input  logic            imem_resp_val,
  input  logic [31:0]     imem_resp_data,
  output blimp_pkg::f_d_t f2d
);
  import blimp_pkg::*;

  logic        run_q;      // Low through reset, then fetch runs
  logic [31:0] pc_q;       // Address of the next request
  logic [31:0] resp_pc_q;  // Address of the request in flight
  f_d_t        hold_q;     // Parked response

  // Hold buffer drains in any cycle without a stall
  assign imem_req  = run_q && !decode_stall;
  assign imem_addr = pc_q;

  always_comb begin
    if (hold_q.val) begin
      f2d = hold_q;                 // Parked entry goes first
    end else begin
      f2d.val  = imem_resp_val;     // Response passes straight through
      f2d.pc   = resp_pc_q;
      f2d.inst = imem_resp_data;
    end
  end

  always_ff @(posedge clk) begin
    if (imem_req) begin
      resp_pc_q <= pc_q;            // Tag for next cycle's response
    end
    if (!hold_q.val && imem_resp_val && decode_stall) begin
      hold_q.pc   <= resp_pc_q;
      hold_q.inst <= imem_resp_data;
    end
    if (!rst_n) begin
      run_q      <= 1'b0;
      pc_q       <= '0;
      hold_q.val <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (imem_req) pc_q <= pc_q + 32'd4;
      if (hold_q.val) begin
        if (!decode_stall) hold_q.val <= 1'b0;  // Decode took it
      end else if (imem_resp_val && decode_stall) begin
        hold_q.val <= 1'b1;                     // Park the response
      end
    end
  end

  // Memory answers one cycle after each request and never unprompted
  assert property (@(posedge clk) disable iff (!rst_n)
    imem_resp_val |-> $past(imem_req))
    else $error("fetch_unit: response without a request");

endmodule

//--- hw/decode_issue_unit.sv
//------------------------------------------------------------
// Decode and issue unit
// Decodes ADD, ADDI and MUL, reads the register file, stalls
// on scoreboard hits or a full sequence space, and dispatches
//------------------------------------------------------------

`timescale 1ns/1ns

module decode_issue_unit #(
  parameter int p_seq_num_bits = blimp_pkg::c_seq_bits
) (
  input  logic               clk,
  input  logic               rst_n,
  input  blimp_pkg::f_d_t    f2d,
  output logic               decode_stall,
  output blimp_pkg::d_x_t    d2alu,
  output blimp_pkg::d_x_t    d2mul,
  input  blimp_pkg::commit_t commit
);
  import blimp_pkg::*;

  localparam int rob_depth = 1 << p_seq_num_bits;

  // Instruction fields
  logic [6:0]  opcode;
  logic [4:0]  rd;
  logic [2:0]  funct3;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [6:0]  funct7;
  logic [31:0] imm_i;

  op_t         op;
  logic        uses_rs1;
  logic        uses_rs2;
  logic        wen;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;

  // Architectural state
  logic [31:0] rf_q [32];
  logic [31:0] sb_q;        // Pending write per register
  logic [p_seq_num_bits-1:0] seq_q;
  logic [p_seq_num_bits:0]   inflight_q;

  logic hazard;
  logic full;
  logic issue;
  pipe_id_t pipe;
  logic [c_num_pipes-1:0] dispatch_val;
  d_x_t issue_pkt;

  assign opcode = f2d.inst[6:0];
  assign rd     = f2d.inst[11:7];
  assign funct3 = f2d.inst[14:12];
  assign rs1    = f2d.inst[19:15];
  assign rs2    = f2d.inst[24:20];
  assign funct7 = f2d.inst[31:25];
  assign imm_i  = {{20{f2d.inst[31]}}, f2d.inst[31:20]};  // Sign extended

  always_comb begin
    op = op_nop;
    if (opcode == c_opc_op && funct3 == c_f3_add) begin
      if (funct7 == c_f7_add) op = op_add;
      else if (funct7 == c_f7_mul) op = op_mul;
    end else if (opcode == c_opc_op_imm && funct3 == c_f3_add) begin
      op = op_addi;
    end
  end

  assign uses_rs1 = (op != op_nop);
  assign uses_rs2 = (op == op_add) || (op == op_mul);
  assign wen      = (op != op_nop) && (rd != 5'd0);  // x0 never written

  assign rs1_data = (rs1 == 5'd0) ? '0 : rf_q[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : rf_q[rs2];

  //------------------------------------------------------------
  // Stall and dispatch
  //------------------------------------------------------------

  assign hazard = (uses_rs1 && sb_q[rs1]) || (uses_rs2 && sb_q[rs2])
               || (wen && sb_q[rd]);
  assign full   = (inflight_q == (p_seq_num_bits + 1)'(rob_depth));

  assign decode_stall = f2d.val && (hazard || full);
  assign issue        = f2d.val && !decode_stall;
  assign pipe         = (op == op_mul) ? pipe_mul : pipe_alu;  // No-ops go to ALU

  always_comb begin
    issue_pkt.val   = issue;
    issue_pkt.seq   = seq_q;
    issue_pkt.pc    = f2d.pc;
    issue_pkt.waddr = rd;
    issue_pkt.wen   = wen;
    issue_pkt.op    = op;
    issue_pkt.op_a  = uses_rs1 ? rs1_data : '0;
    if (op == op_addi) issue_pkt.op_b = imm_i;
    else if (uses_rs2) issue_pkt.op_b = rs2_data;
    else issue_pkt.op_b = '0;                  // No-op sums to 0
  end

  always_comb begin
    dispatch_val       = '0;
    dispatch_val[pipe] = issue_pkt.val;        // Steer the strobe
    d2alu              = issue_pkt;
    d2alu.val          = dispatch_val[pipe_alu];
    d2mul              = issue_pkt;
    d2mul.val          = dispatch_val[pipe_mul];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) rf_q[i] <= '0;
      sb_q       <= '0;
      seq_q      <= '0;
      inflight_q <= '0;
    end else begin
      if (commit.val && commit.wen) begin
        rf_q[commit.waddr] <= commit.wdata;    // Visible next cycle
        sb_q[commit.waddr] <= 1'b0;
      end
      if (issue) begin
        seq_q <= seq_q + 1'b1;                 // Wraps with the ROB
        if (wen) sb_q[rd] <= 1'b1;
      end
      case ({issue, commit.val})
        2'b10:   inflight_q <= inflight_q + 1'b1;
        2'b01:   inflight_q <= inflight_q - 1'b1;
        default: inflight_q <= inflight_q;
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({d2alu.val, d2mul.val}))
    else $error("decode_issue_unit: dispatch to both pipes");

endmodule

//--- hw/alu_unit.sv
//------------------------------------------------------------
// ALU pipe
// Single-cycle adder for ADD and ADDI, also retires no-ops
//------------------------------------------------------------

`timescale 1ns/1ns

module alu_unit (
  input  logic            clk,
  input  logic            rst_n,
  input  blimp_pkg::d_x_t d2alu,
  output blimp_pkg::x_w_t alu2w
);
  import blimp_pkg::*;

  logic [31:0] result;

  // ADDI already has its immediate in op_b
  always_comb begin
    case (d2alu.op)
      op_add,
      op_addi: result = d2alu.op_a + d2alu.op_b;
      default: result = '0;   // No-op writes nothing useful
    endcase
  end

  always_ff @(posedge clk) begin
    // Metadata follows the result to writeback
    alu2w.seq   <= d2alu.seq;
    alu2w.pc    <= d2alu.pc;
    alu2w.waddr <= d2alu.waddr;
    alu2w.wen   <= d2alu.wen;
    alu2w.wdata <= result;
    if (!rst_n) begin
      alu2w.val <= 1'b0;
    end else begin
      alu2w.val <= d2alu.val;
    end
  end

endmodule

//--- hw/pipelined_multiplier.sv
//------------------------------------------------------------
// Multiplier pipe
// Low 32 bits of the product in the first stage, then a chain
// of register stages; several multiplies can be in flight
//------------------------------------------------------------

`timescale 1ns/1ns

module pipelined_multiplier #(
  parameter int p_pipeline_stages = 4
) (
  input  logic            clk,
  input  logic            rst_n,
  input  blimp_pkg::d_x_t d2mul,
  output blimp_pkg::x_w_t mul2w
);
  import blimp_pkg::*;

  x_w_t        stage_q [p_pipeline_stages];  // Valid bit per stage
  logic [31:0] product;

  assign product = d2mul.op_a * d2mul.op_b;  // Truncated to low word

  //------------------------------------------------------------
  // Stage chain
  //------------------------------------------------------------

  always_ff @(posedge clk) begin
    stage_q[0].seq   <= d2mul.seq;
    stage_q[0].pc    <= d2mul.pc;
    stage_q[0].waddr <= d2mul.waddr;
    stage_q[0].wen   <= d2mul.wen;
    stage_q[0].wdata <= product;
    stage_q[0].val   <= d2mul.val;
    for (int i = 1; i < p_pipeline_stages; i++) begin
      stage_q[i] <= stage_q[i-1];            // Shift data and metadata
    end
    if (!rst_n) begin
      for (int i = 0; i < p_pipeline_stages; i++) begin
        stage_q[i].val <= 1'b0;              // Empty pipe
      end
    end
  end

  // Last stage completes p_pipeline_stages cycles after issue
  assign mul2w = stage_q[p_pipeline_stages-1];

endmodule

//--- hw/writeback_commit_unit.sv
//------------------------------------------------------------
// Writeback and commit unit
// Reorder buffer indexed by sequence number, filled from both
// pipes, retired one entry per cycle in program order
//------------------------------------------------------------

`timescale 1ns/1ns

module writeback_commit_unit #(
  parameter int p_seq_num_bits = blimp_pkg::c_seq_bits
) (
  input  logic               clk,
  input  logic               rst_n,
  input  blimp_pkg::x_w_t    alu2w,
  input  blimp_pkg::x_w_t    mul2w,
  output blimp_pkg::commit_t commit
);

  localparam int rob_depth = 1 << p_seq_num_bits;

  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  waddr;
    logic        wen;
    logic [31:0] wdata;
  } rob_entry_t;

  rob_entry_t                rob_q [rob_depth];  // Payload only
  logic [rob_depth-1:0]      done_q;             // Completed, not retired
  logic [p_seq_num_bits-1:0] head_q;             // Oldest in flight

  //------------------------------------------------------------
  // Completion
  //------------------------------------------------------------

  // Each pipe writes its own entry, both may land together
  always_ff @(posedge clk) begin
    if (alu2w.val) begin
      rob_q[alu2w.seq] <= '{pc:    alu2w.pc,
                            waddr: alu2w.waddr,
                            wen:   alu2w.wen,
                            wdata: alu2w.wdata};
    end
    if (mul2w.val) begin
      rob_q[mul2w.seq] <= '{pc:    mul2w.pc,
                            waddr: mul2w.waddr,
                            wen:   mul2w.wen,
                            wdata: mul2w.wdata};
    end
  end

  //------------------------------------------------------------
  // In-order commit
  //------------------------------------------------------------

  assign commit.val   = done_q[head_q];    // Head ready, retire now
  assign commit.seq   = head_q;
  assign commit.pc    = rob_q[head_q].pc;
  assign commit.waddr = rob_q[head_q].waddr;
  assign commit.wen   = rob_q[head_q].wen;
  assign commit.wdata = rob_q[head_q].wdata;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done_q <= '0;
      head_q <= '0;
    end else begin
      if (commit.val) begin
        done_q[head_q] <= 1'b0;            // Free the slot
        head_q         <= head_q + 1'b1;
      end
      if (alu2w.val) done_q[alu2w.seq] <= 1'b1;
      if (mul2w.val) done_q[mul2w.seq] <= 1'b1;
    end
  end

  // Sequence allocation in decode must keep entries unique
  assert property (@(posedge clk) disable iff (!rst_n)
    alu2w.val |-> !done_q[alu2w.seq])
    else $error("writeback_commit_unit: ALU overwrote a done entry");

  assert property (@(posedge clk) disable iff (!rst_n)
    mul2w.val |-> !done_q[mul2w.seq])
    else $error("writeback_commit_unit: MUL overwrote a done entry");

endmodule

//--- hw/blimp_core.sv
//------------------------------------------------------------
// Blimp core top level
// In-order issue, out-of-order completion, in-order commit
// for ADD, ADDI and MUL, with an instruction trace
//------------------------------------------------------------

`timescale 1ns/1ns

module blimp_core #(
  parameter int p_seq_num_bits    = 5,
  parameter int p_pipeline_stages = 4
) (
  input  logic        clk,
  input  logic        rst_n,

  // Instruction memory
  output logic        imem_req,
  output logic [31:0] imem_addr,
  input  logic        imem_resp_val,
  input  logic [31:0] imem_resp_data,

  // Commit trace
  output logic        commit_val,
  output logic [31:0] commit_pc,
  output logic [4:0]  commit_waddr,
  output logic        commit_wen,
  output logic [31:0] commit_wdata
);
  import blimp_pkg::*;

  f_d_t    f2d;
  logic    decode_stall;   // Only back-pressure in the core
  d_x_t    d2alu;
  d_x_t    d2mul;
  x_w_t    alu2w;
  x_w_t    mul2w;
  commit_t commit;

  fetch_unit fetch_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .decode_stall   (decode_stall),
    .imem_req       (imem_req),
    .imem_addr      (imem_addr),
    .imem_resp_val  (imem_resp_val),
    .imem_resp_data (imem_resp_data),
    .f2d            (f2d)
  );

  decode_issue_unit #(
    .p_seq_num_bits (p_seq_num_bits)
  ) decode_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .f2d          (f2d),
    .decode_stall (decode_stall),
    .d2alu        (d2alu),
    .d2mul        (d2mul),
    .commit       (commit)
  );

  alu_unit alu_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .d2alu (d2alu),
    .alu2w (alu2w)
  );

  pipelined_multiplier #(
    .p_pipeline_stages (p_pipeline_stages)
  ) mul_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .d2mul (d2mul),
    .mul2w (mul2w)
  );

  writeback_commit_unit #(
    .p_seq_num_bits (p_seq_num_bits)
  ) wcu_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .alu2w  (alu2w),
    .mul2w  (mul2w),
    .commit (commit)
  );

  // Trace straight from the commit notification
  assign commit_val   = commit.val;
  assign commit_pc    = commit.pc;
  assign commit_waddr = commit.waddr;
  assign commit_wen   = commit.wen;
  assign commit_wdata = commit.wdata;

endmodule

//--- tb/clock_gen.sv
//------------------------------------------------------------
// Testbench clock and reset
// Free-running clock, active-low reset held for a few cycles
//------------------------------------------------------------

`timescale 1ns/1ns

module clock_gen #(
  parameter int p_period       = 100,
  parameter int p_reset_cycles = 5
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(p_period / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;                         // Held from time 0
    repeat (p_reset_cycles) @(posedge clk);
    #1 rst_n = 1'b1;                      // Released just after an edge
  end

endmodule

//--- tb/blimp_core_tb.sv
//------------------------------------------------------------
// Blimp core testbench
// Random ADD/ADDI/MUL program, one-cycle instruction memory,
// in-order architectural model and commit stream assertions
//------------------------------------------------------------

`timescale 1ns/1ns

module blimp_core_tb;

  localparam int          c_seq_bits   = 5;
  localparam int          c_mul_stages = 4;
  localparam int          c_prog_len   = 256;
  localparam int          c_seed       = 37;
  localparam int          c_rst_cycles = 5;
  localparam int          c_cycle_lim  = c_rst_cycles + c_prog_len * (c_mul_stages + 6) + 20;
  localparam logic [31:0] c_nop        = 32'h0000_0013;  // ADDI x0, x0, 0

  logic        clk;
  logic        rst_n;
  logic        imem_req;
  logic [31:0] imem_addr;
  logic        imem_resp_val  = 1'b0;
  logic [31:0] imem_resp_data = '0;
  logic        commit_val;
  logic [31:0] commit_pc;
  logic [4:0]  commit_waddr;
  logic        commit_wen;
  logic [31:0] commit_wdata;

  logic [31:0] prog_mem [c_prog_len];
  logic        mem_req_q;
  logic [31:0] mem_addr_q;

  // Architectural model state
  logic [31:0] arch_rf [32];
  int          commit_cnt;
  logic        last_mul;
  logic        last_wen;
  logic [4:0]  last_rd;

  // Expected result of the next instruction in program order
  logic [31:0] exp_pc;
  logic [31:0] cur_inst;
  logic [4:0]  exp_rd;
  logic [4:0]  exp_rs1;
  logic [4:0]  exp_rs2;
  logic [31:0] src_a;
  logic [31:0] src_b;
  logic [31:0] imm_sext;
  logic        exp_is_add;
  logic        exp_is_addi;
  logic        exp_is_mul;
  logic        exp_is_alu;
  logic        exp_wen;
  logic [31:0] exp_wdata;

  int cycle_cnt    = 0;
  int alu_hits     = 0;
  int mul_hits     = 0;
  int dep_mul_hits = 0;
  int nop_hits     = 0;
  int reset_errs    = 0;
  int first_pc_errs = 0;
  int pc_errs       = 0;
  int alu_errs      = 0;
  int mul_errs      = 0;
  int wen_errs      = 0;
  int waddr_errs    = 0;
  int x0_errs       = 0;
  int pass_tests    = 0;
  int fail_tests    = 0;
  logic timed_out   = 1'b0;

  clock_gen #(
    .p_period       (100),
    .p_reset_cycles (c_rst_cycles)
  ) clock_inst (
    .clk   (clk),
    .rst_n (rst_n)
  );

  blimp_core #(
    .p_seq_num_bits    (c_seq_bits),
    .p_pipeline_stages (c_mul_stages)
  ) blimp_core_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .imem_req       (imem_req),
    .imem_addr      (imem_addr),
    .imem_resp_val  (imem_resp_val),
    .imem_resp_data (imem_resp_data),
    .commit_val     (commit_val),
    .commit_pc      (commit_pc),
    .commit_waddr   (commit_waddr),
    .commit_wen     (commit_wen),
    .commit_wdata   (commit_wdata)
  );

  //------------------------------------------------------------
  // Program generation and instruction memory
  //------------------------------------------------------------

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] addi_word(input logic [4:0] rd, rs1,
                                            input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] read_program(input logic [31:0] addr);
    if (addr < 32'(c_prog_len * 4)) return prog_mem[addr[9:2]];
    return c_nop;                              // Past the end of the program
  endfunction

  task automatic fill_program();
    int         kind;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    for (int i = 0; i < c_prog_len; i++) begin
      kind = $urandom_range(15, 0);
      rd   = 5'($urandom_range(7, 0));       // x0..x7 keeps hazards frequent
      rs1  = 5'($urandom_range(7, 0));
      rs2  = 5'($urandom_range(7, 0));
      if (kind < 5) prog_mem[i] = r_type(7'h00, 3'h0, rd, rs1, rs2);
      else if (kind < 10) prog_mem[i] = addi_word(rd, rs1, 12'($urandom));
      else if (kind < 15) prog_mem[i] = r_type(7'h01, 3'h0, rd, rs1, rs2);
      else prog_mem[i] = r_type(7'h20, 3'h0, rd, rs1, rs2);  // SUB, outside subset
    end
    // Chain of dependent multiplies
    prog_mem[200] = addi_word(5'd5, 5'd0, 12'd3);
    prog_mem[201] = addi_word(5'd6, 5'd0, 12'hff9);        // -7
    for (int i = 202; i < 210; i++) prog_mem[i] = r_type(7'h01, 3'h0, 5'd5, 5'd5, 5'd6);
  endtask

  // Answers each request one cycle later
  always @(posedge clk) begin
    mem_req_q  = (imem_req === 1'b1);
    mem_addr_q = imem_addr;
    #1;
    imem_resp_val  = mem_req_q;
    imem_resp_data = read_program(mem_addr_q);
  end

  //------------------------------------------------------------
  // Architectural model
  //------------------------------------------------------------

  always_comb begin
    exp_pc      = 32'(commit_cnt) << 2;         // One word per retired instruction
    cur_inst    = read_program(exp_pc);
    exp_rd      = cur_inst[11:7];
    exp_rs1     = cur_inst[19:15];
    exp_rs2     = cur_inst[24:20];
    src_a       = (exp_rs1 == 5'd0) ? 32'h0 : arch_rf[exp_rs1];
    src_b       = (exp_rs2 == 5'd0) ? 32'h0 : arch_rf[exp_rs2];
    imm_sext    = {{20{cur_inst[31]}}, cur_inst[31:20]};
    exp_is_add  = cur_inst[6:0] == 7'h33 && cur_inst[14:12] == 3'h0 && cur_inst[31:25] == 7'h00;
    exp_is_mul  = cur_inst[6:0] == 7'h33 && cur_inst[14:12] == 3'h0 && cur_inst[31:25] == 7'h01;
    exp_is_addi = cur_inst[6:0] == 7'h13 && cur_inst[14:12] == 3'h0;
    exp_is_alu  = exp_is_add || exp_is_addi;
    exp_wen     = (exp_is_alu || exp_is_mul) && exp_rd != 5'd0;
    if (exp_is_add) exp_wdata = src_a + src_b;
    else if (exp_is_addi) exp_wdata = src_a + imm_sext;
    else if (exp_is_mul) exp_wdata = src_a * src_b;   // Low word only
    else exp_wdata = 32'h0;
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // Retires one instruction per DUT commit
  always @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) arch_rf[i] <= 32'h0;
      commit_cnt <= 0;
      last_mul   <= 1'b0;
      last_wen   <= 1'b0;
      last_rd    <= 5'd0;
    end else if (commit_val) begin
      if (exp_wen) arch_rf[exp_rd] <= exp_wdata;
      commit_cnt <= commit_cnt + 1;
      last_mul   <= exp_is_mul;
      last_wen   <= exp_wen;
      last_rd    <= exp_rd;
      if (exp_is_alu) alu_hits <= alu_hits + 1;
      if (!exp_wen) nop_hits <= nop_hits + 1;
      if (exp_is_mul) begin
        mul_hits <= mul_hits + 1;
        if (last_mul && last_wen && (exp_rs1 == last_rd || exp_rs2 == last_rd)) begin
          dep_mul_hits <= dep_mul_hits + 1;   // Back-to-back dependent pair
        end
      end
    end
  end

  //------------------------------------------------------------
  // Commit stream checks
  //------------------------------------------------------------

  assert property (@(posedge clk) (!rst_n && cycle_cnt != 0) |-> !commit_val && !imem_req)
    else begin
      reset_errs = reset_errs + 1;
      $display("FAIL commit_val/imem_req in reset: expected 0/0, got %h/%h",
               $sampled(commit_val), $sampled(imem_req));
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    commit_val && commit_cnt == 0 |-> commit_pc == 32'h0)
    else begin
      first_pc_errs = first_pc_errs + 1;
      $display("FAIL commit_pc on first commit: expected 00000000, got %h", $sampled(commit_pc));
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    commit_val && commit_cnt != 0 |-> commit_pc == exp_pc)
    else begin
      pc_errs = pc_errs + 1;
      $display("FAIL commit_pc: expected %h, got %h", $sampled(exp_pc),
               $sampled(commit_pc));
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    commit_val && exp_is_alu && exp_wen |-> commit_wdata == exp_wdata)
    else begin
      alu_errs = alu_errs + 1;
      $display("FAIL commit_wdata (ADD/ADDI at %h): expected %h, got %h", $sampled(commit_pc),
               $sampled(exp_wdata), $sampled(commit_wdata));
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    commit_val && exp_is_mul && exp_wen |-> commit_wdata == exp_wdata)
    else begin
      mul_errs = mul_errs + 1;
      $display("FAIL commit_wdata (MUL at %h): expected %h, got %h", $sampled(commit_pc),
               $sampled(exp_wdata), $sampled(commit_wdata));
    end

  assert property (@(posedge clk) disable iff (!rst_n) commit_val |-> commit_wen == exp_wen)
    else begin
      wen_errs = wen_errs + 1;
      $display("FAIL commit_wen at %h: expected %h, got %h", $sampled(commit_pc),
               $sampled(exp_wen), $sampled(commit_wen));
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    commit_val && exp_wen |-> commit_waddr == exp_rd)
    else begin
      waddr_errs = waddr_errs + 1;
      $display("FAIL commit_waddr at %h: expected %h, got %h", $sampled(commit_pc),
               $sampled(exp_rd), $sampled(commit_waddr));
    end

  // x0 is hardwired, so the trace never shows a write to it
  assert property (@(posedge clk) disable iff (!rst_n)
    commit_val && commit_waddr == 5'd0 |-> !commit_wen)
    else begin
      x0_errs = x0_errs + 1;
      $display("FAIL commit_wen for x0 at %h: expected 0, got %h", $sampled(commit_pc),
               $sampled(commit_wen));
    end

  //------------------------------------------------------------
  // Run control and reporting
  //------------------------------------------------------------

  task automatic wait_commits(input int target);
    while (commit_cnt < target && !timed_out) begin
      @(posedge clk);
      if (cycle_cnt >= c_cycle_lim) begin
        timed_out = 1'b1;
        $display("Timeout after %0d cycles with %0d of %0d instructions committed",
                 cycle_cnt, commit_cnt, c_prog_len);
      end
    end
  endtask

  // Zero hits means the stimulus never reached the check
  task automatic report_test(input string name, input int errs, input int hits);
    if (errs == 0 && hits > 0) begin
      pass_tests = pass_tests + 1;
      $display("test %-20s ok, %0d checks", name, hits);
    end else begin
      fail_tests = fail_tests + 1;
      if (hits == 0) $display("test %-20s never reached its checks", name);
      else $display("test %-20s FAILED with %0d errors", name, errs);
    end
  endtask

  initial begin
    void'($urandom(c_seed));
    fill_program();
    wait (rst_n === 1'b1);
    wait_commits(1);
    report_test("reset_and_first_pc", reset_errs + first_pc_errs, (commit_cnt > 0) ? 1 : 0);
    wait_commits(c_prog_len);
    report_test("in_order_pc", pc_errs, commit_cnt);
    report_test("alu_results", alu_errs, alu_hits);
    report_test("mul_results", mul_errs, (dep_mul_hits > 0) ? mul_hits : 0);
    report_test("x0_and_nop", wen_errs + waddr_errs + x0_errs, nop_hits);
    report_test("all_committed", timed_out ? 1 : 0, commit_cnt);
    $display("Summary: %0d tests, %0d passed, %0d failed, %0d commits in %0d cycles",
             pass_tests + fail_tests, pass_tests, fail_tests, commit_cnt, cycle_cnt);
    if (fail_tests == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- src.f
hw/blimp_pkg.sv
hw/fetch_unit.sv
hw/decode_issue_unit.sv
hw/alu_unit.sv
hw/pipelined_multiplier.sv
hw/writeback_commit_unit.sv
hw/blimp_core.sv
tb/clock_gen.sv
tb/blimp_core_tb.sv

//--- run.sh
#!/bin/sh
# Build the core testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --assert --timescale 1ns/1ns -Wno-fatal \
  --top-module blimp_core_tb -f src.f -o blimp_sim &&
./obj_dir/blimp_sim | tee /dev/stderr | grep -F "All tests passed" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
